//--- compile.f
+incdir+common
common/zap_pkg.sv
logic/zap_dual_rank_synchronizer.sv
adapter/zap_sync_fifo.sv
adapter/zap_wb_adapter.sv
merger/zap_wb_merger.sv
logic/zap_mem_top.sv
sim/zap_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module zap_mem_tb -f compile.f -o zap_mem_sim > build.log 2>&1 \
        || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/zap_mem_sim > sim.log 2>&1

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"

//--- sim/zap_mem_tb.sv
// ZAP memory fabric testbench.
// Random code and data traffic against a reference memory,
// a Wishbone slave model with random wait states, write order
// tracking and a check on the interrupt synchronizer delay.

`include "zap_defs.svh"

module zap_mem_tb;

        timeunit 1ns;
        timeprecision 1ps;

        import zap_pkg::*;

        localparam int        NUM_REQ        = 2000;
        localparam int        TIMEOUT_CYCLES = NUM_REQ * 40 + 10;
        localparam int        MAX_WAIT       = 200;
        localparam zap_word_t BASE           = 32'h0000_1000;  // 64-word window.

        localparam int T_RESET    = 0;
        localparam int T_WR_ORDER = 1;
        localparam int T_DATA_RD  = 2;
        localparam int T_CODE_RD  = 3;
        localparam int T_FAIR     = 4;
        localparam int T_IRQ      = 5;
        localparam int NUM_TESTS  = 6;

        logic                   i_clk;
        logic                   i_rst_n;
        logic                   i_irq;
        logic                   i_fiq;
        logic                   o_irq;
        logic                   o_fiq;
        logic                   i_code_stb;
        zap_word_t              i_code_adr;
        zap_wb_rsp_t            o_code_rsp;
        logic                   i_data_stb;
        zap_wb_req_t            i_data_req;
        zap_wb_rsp_t            o_data_rsp;
        logic                   o_wb_cyc;
        logic                   o_wb_stb;
        logic                   o_wb_we;
        zap_word_t              o_wb_adr;
        logic [`ZAP_SEL_W-1:0]  o_wb_sel;
        zap_word_t              o_wb_dat;
        logic                   i_wb_ack;
        zap_word_t              i_wb_dat;

        integer      seed;
        int          cycles = 0;
        zap_word_t   ref_mem [64];      // Updated in ack order.
        zap_word_t   slave_mem [64];    // Updated by bus writes.
        zap_wb_req_t wr_queue [$];      // Acked writes not yet on the bus.
        int          checks [NUM_TESTS];
        int          errors [NUM_TESTS];
        string       test_name [NUM_TESTS] = '{"reset", "write order", "data read",
                                               "code read", "fairness", "irq sync"};

        zap_mem_top i_dut (.*);

        // ------------------------------
        // Helpers
        // ------------------------------

        function automatic zap_word_t next_rand();
                return $random(seed);
        endfunction

        function automatic zap_word_t fill_word(input int idx);
                zap_word_t a;
                a = BASE + zap_word_t'(idx * 4);
                return {~a[15:0], a[15:0]} ^ {a[31:16], a[31:16]} ^ 32'h3c5a_0000;
        endfunction

        function automatic zap_word_t merge_lanes(input zap_word_t old_word,
                                                  input zap_wb_req_t req);
                zap_word_t w;
                w = old_word;
                for (int b = 0; b < 4; b++)
                        if (req.sel[b])
                                w[8*b +: 8] = req.dat[8*b +: 8];
                return w;
        endfunction

        // Fields shown as adr/we/sel/dat.
        task automatic check_req(input int t, input zap_wb_req_t exp, input zap_wb_req_t act);
                checks[t]++;
                if (exp !== act)
                begin
                        errors[t]++;
                        $display("Mismatch %s: expected %h/%b/%h/%h, actual %h/%b/%h/%h",
                                 test_name[t], exp.adr, exp.we, exp.sel, exp.dat,
                                 act.adr, act.we, act.sel, act.dat);
                end
        endtask

        task automatic check_word(input int t, input zap_word_t exp, input zap_word_t act);
                checks[t]++;
                if (exp !== act)
                begin
                        errors[t]++;
                        $display("Mismatch %s: expected %h, actual %h", test_name[t], exp, act);
                end
        endtask

        task automatic check_bit(input int t, input logic exp, input logic act);
                checks[t]++;
                if (exp !== act)
                begin
                        errors[t]++;
                        $display("Mismatch %s: expected %b, actual %b", test_name[t], exp, act);
                end
        endtask

        task automatic note_error(input int t, input string msg);
                errors[t]++;
                $display("Error in %s: %s", test_name[t], msg);
        endtask

        task automatic report_test(input int t);
                $display("Test %s done: %0d checks, %0d errors",
                         test_name[t], checks[t], errors[t]);
        endtask

        // ------------------------------
        // Clock and watchdog
        // ------------------------------

        initial
        begin
                i_clk = 1'b0;
                forever #50 i_clk = ~i_clk;
        end

        always @(posedge i_clk)
                cycles <= cycles + 1;

        initial
        begin
                wait (cycles >= TIMEOUT_CYCLES);
                $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
                $display("TESTBENCH FAILED");
                $finish;
        end

        // ------------------------------
        // Stimulus, slave model, checks
        // ------------------------------

        initial
        begin : stimulus
                logic        code_busy;
                zap_word_t   code_adr;
                int          code_wait;
                logic        data_busy;
                zap_wb_req_t data_req;
                int          data_wait;
                int          issued;
                int          done;
                logic        saturate;
                logic        slv_busy;
                logic        slv_ack;
                int          slv_wait;
                zap_word_t   slv_dat;
                logic [1:0]  irq_hist [3];      // {fiq, irq}, newest first.
                zap_word_t   r;
                zap_wb_req_t bus_req;
                int          total_checks;
                int          total_errors;

                seed       = 32'h035d6fda;
                i_rst_n    = 1'b0;
                i_irq      = 1'b0;
                i_fiq      = 1'b0;
                i_code_stb = 1'b0;
                i_code_adr = '0;
                i_data_stb = 1'b0;
                i_data_req = '0;
                i_wb_ack   = 1'b0;
                i_wb_dat   = '0;
                code_busy  = 1'b0;
                code_adr   = BASE;
                code_wait  = 0;
                data_busy  = 1'b0;
                data_req   = '0;
                data_wait  = 0;
                issued     = 0;
                done       = 0;
                saturate   = 1'b0;
                slv_busy   = 1'b0;
                slv_ack    = 1'b0;
                slv_wait   = 0;
                slv_dat    = '0;
                for (int i = 0; i < 3; i++)
                        irq_hist[i] = 2'b00;
                for (int i = 0; i < 64; i++)
                begin
                        ref_mem[i]   = fill_word(i);
                        slave_mem[i] = fill_word(i);
                end
                for (int t = 0; t < NUM_TESTS; t++)
                begin
                        checks[t] = 0;
                        errors[t] = 0;
                end

                repeat (5) @(posedge i_clk);
                #1 i_rst_n = 1'b1;
                @(negedge i_clk);
                check_bit(T_RESET, 1'b0, o_wb_cyc);
                check_bit(T_RESET, 1'b0, o_wb_stb);
                check_bit(T_RESET, 1'b0, o_code_rsp.ack);
                check_bit(T_RESET, 1'b0, o_data_rsp.ack);
                check_bit(T_RESET, 1'b0, o_irq);
                check_bit(T_RESET, 1'b0, o_fiq);
                report_test(T_RESET);

                while (done < NUM_REQ || wr_queue.size() != 0)
                begin
                        // Code port response.
                        if (o_code_rsp.ack)
                        begin
                                if (!code_busy)
                                        note_error(T_CODE_RD, "code ack without an open request");
                                else
                                begin
                                        check_word(T_CODE_RD, ref_mem[code_adr[7:2]],
                                                   o_code_rsp.dat);
                                        checks[T_FAIR]++;
                                        code_busy = 1'b0;
                                        done++;
                                end
                        end
                        else if (code_busy)
                        begin
                                code_wait++;
                                if (code_wait == MAX_WAIT + 1)
                                        note_error(T_FAIR, "code port starved for over 200 cycles");
                        end

                        // Data port response.
                        if (o_data_rsp.ack)
                        begin
                                if (!data_busy)
                                        note_error(T_DATA_RD, "data ack without an open request");
                                else
                                begin
                                        if (data_req.we)
                                        begin
                                                ref_mem[data_req.adr[7:2]] = merge_lanes(
                                                        ref_mem[data_req.adr[7:2]], data_req);
                                                wr_queue.push_back(data_req);
                                        end
                                        else
                                                check_word(T_DATA_RD, ref_mem[data_req.adr[7:2]],
                                                           o_data_rsp.dat);
                                        checks[T_FAIR]++;
                                        data_busy = 1'b0;
                                        done++;
                                end
                        end
                        else if (data_busy)
                        begin
                                data_wait++;
                                if (data_wait == MAX_WAIT + 1)
                                        note_error(T_FAIR, "data port starved for over 200 cycles");
                        end

                        // Wishbone slave with 0 to 3 wait cycles.
                        if (slv_ack)
                        begin
                                slv_ack  = 1'b0;
                                slv_busy = 1'b0;
                        end
                        else if (o_wb_cyc && o_wb_stb)
                        begin
                                if (!slv_busy)
                                begin
                                        slv_busy = 1'b1;
                                        r        = next_rand();
                                        slv_wait = int'(r[1:0]);
                                end
                                if (slv_wait != 0)
                                        slv_wait--;
                                else if (o_wb_we)
                                begin
                                        bus_req.adr = o_wb_adr;
                                        bus_req.we  = o_wb_we;
                                        bus_req.sel = o_wb_sel;
                                        bus_req.dat = o_wb_dat;
                                        if (wr_queue.size() == 0)
                                                note_error(T_WR_ORDER,
                                                           "bus write with no write pending");
                                        else
                                                check_req(T_WR_ORDER, wr_queue.pop_front(),
                                                          bus_req);
                                        slave_mem[o_wb_adr[7:2]] =
                                                merge_lanes(slave_mem[o_wb_adr[7:2]], bus_req);
                                        slv_ack = 1'b1;
                                end
                                else
                                begin
                                        slv_dat = slave_mem[o_wb_adr[7:2]];
                                        slv_ack = 1'b1;
                                end
                        end

                        check_bit(T_IRQ, irq_hist[2][0], o_irq);   // Two edges back.
                        check_bit(T_IRQ, irq_hist[2][1], o_fiq);

                        // New requests. Second half keeps both ports asking.
                        saturate = (issued >= NUM_REQ / 2);
                        r = next_rand();
                        if (!code_busy && issued < NUM_REQ && (r[0] || saturate))
                        begin
                                code_busy = 1'b1;
                                code_wait = 0;
                                code_adr  = BASE + {24'h0, r[13:8], 2'b00};
                                issued++;
                        end
                        r = next_rand();
                        if (!data_busy && issued < NUM_REQ && (r[0] || saturate))
                        begin
                                data_busy    = 1'b1;
                                data_wait    = 0;
                                data_req.adr = BASE + {24'h0, r[13:8], 2'b00};
                                data_req.we  = r[1] | r[2];     // Mostly writes.
                                data_req.sel = data_req.we ? r[7:4] : 4'hf;
                                data_req.dat = data_req.we ? next_rand() : '0;
                                issued++;
                        end

                        @(posedge i_clk);
                        #1;
                        r = next_rand();
                        irq_hist[2] = irq_hist[1];
                        irq_hist[1] = irq_hist[0];
                        if (r[2:0] == 3'd0)
                                irq_hist[0] = r[5:4];
                        {i_fiq, i_irq} = irq_hist[0];
                        i_code_stb = code_busy;
                        i_code_adr = code_adr;
                        i_data_stb = data_busy;
                        i_data_req = data_req;
                        i_wb_ack   = slv_ack;
                        i_wb_dat   = slv_ack ? slv_dat : '0;
                        @(negedge i_clk);
                end

                total_checks = 0;
                total_errors = 0;
                for (int t = 1; t < NUM_TESTS; t++)
                        report_test(t);
                for (int t = 0; t < NUM_TESTS; t++)
                begin
                        total_checks += checks[t];
                        total_errors += errors[t];
                end
                $display("Total: %0d checks, %0d errors", total_checks, total_errors);
                if (total_errors == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

//--- logic/zap_mem_top.sv
// ZAP memory-side fabric top level.
// Interrupt synchronizer, code/data merger and the store
// buffer Wishbone adapter, wired together.

`include "zap_defs.svh"

module zap_mem_top (
        input  logic                   i_clk,
        input  logic                   i_rst_n,

        // Level interrupts, active high.
        input  logic                   i_irq,
        input  logic                   i_fiq,
        output logic                   o_irq,
        output logic                   o_fiq,

        // Code port.
        input  logic                   i_code_stb,
        input  zap_pkg::zap_word_t     i_code_adr,
        output zap_pkg::zap_wb_rsp_t   o_code_rsp,

        // Data port.
        input  logic                   i_data_stb,
        input  zap_pkg::zap_wb_req_t   i_data_req,
        output zap_pkg::zap_wb_rsp_t   o_data_rsp,

        // ------------------------------
        // External Wishbone
        // ------------------------------

        output logic                   o_wb_cyc,
        output logic                   o_wb_stb,
        output logic                   o_wb_we,
        output zap_pkg::zap_word_t     o_wb_adr,
        output logic [`ZAP_SEL_W-1:0]  o_wb_sel,
        output zap_pkg::zap_word_t     o_wb_dat,
        input  logic                   i_wb_ack,
        input  zap_pkg::zap_word_t     i_wb_dat
);

        import zap_pkg::*;

        logic        req_stb;
        zap_wb_req_t req;
        zap_wb_rsp_t rsp;

        zap_dual_rank_synchronizer #(.WIDTH(2)) u_sync (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_in    ({i_fiq, i_irq}),
                .o_out   ({o_fiq, o_irq})
        );

        zap_wb_merger u_zap_wb_merger (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_code_stb (i_code_stb),
                .i_code_adr (i_code_adr),
                .o_code_rsp (o_code_rsp),
                .i_data_stb (i_data_stb),
                .i_data_req (i_data_req),
                .o_data_rsp (o_data_rsp),
                .o_req_stb  (req_stb),
                .o_req      (req),
                .i_rsp      (rsp)
        );

        zap_wb_adapter #(.DEPTH(`ZAP_STORE_BUFFER_DEPTH)) u_zap_wb_adapter (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_req_stb (req_stb),
                .i_req     (req),
                .o_rsp     (rsp),
                .o_wb_cyc  (o_wb_cyc),
                .o_wb_stb  (o_wb_stb),
                .o_wb_we   (o_wb_we),
                .o_wb_adr  (o_wb_adr),
                .o_wb_sel  (o_wb_sel),
                .o_wb_dat  (o_wb_dat),
                .i_wb_ack  (i_wb_ack),
                .i_wb_dat  (i_wb_dat)
        );

endmodule

//--- merger/zap_wb_merger.sv
// Code/data request merger.
// Arbitrates the code read port and the data port onto one
// internal request path. A grant is registered when idle and
// held until the adapter acks. On contention the port that was
// not served last wins. Code requests become full-word reads.

module zap_wb_merger (
        input  logic                i_clk,
        input  logic                i_rst_n,

        // Code port, read only.
        input  logic                i_code_stb,
        input  zap_pkg::zap_word_t  i_code_adr,
        output zap_pkg::zap_wb_rsp_t o_code_rsp,

        // Data port.
        input  logic                i_data_stb,
        input  zap_pkg::zap_wb_req_t i_data_req,
        output zap_pkg::zap_wb_rsp_t o_data_rsp,

        // Internal path to the adapter.
        output logic                o_req_stb,
        output zap_pkg::zap_wb_req_t o_req,
        input  zap_pkg::zap_wb_rsp_t i_rsp
);

        import zap_pkg::*;

        zap_grant_e  grant_q;           // Also the last served port when idle.
        zap_grant_e  grant_nxt;
        logic        busy_q;
        zap_wb_req_t code_req;

        // ------------------------------
        // Arbitration
        // ------------------------------

        always_comb
        begin
                grant_nxt = grant_q;
                if (i_code_stb && i_data_stb)
                        // Both asking. Alternate.
                        grant_nxt = (grant_q == GRANT_DATA) ? GRANT_CODE : GRANT_DATA;
                else if (i_code_stb)
                        grant_nxt = GRANT_CODE;
                else if (i_data_stb)
                        grant_nxt = GRANT_DATA;
        end

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        busy_q  <= 1'b0;
                        grant_q <= GRANT_DATA;
                end
                else if (!busy_q)
                begin
                        busy_q  <= i_code_stb | i_data_stb;
                        grant_q <= grant_nxt;
                end
                else if (i_rsp.ack)
                begin
                        busy_q  <= 1'b0;        // One idle cycle follows.
                end
        end

        // ------------------------------
        // Request and response steering
        // ------------------------------

        always_comb
        begin
                code_req.adr = i_code_adr;
                code_req.we  = 1'b0;
                code_req.sel = '1;              // Whole word.
                code_req.dat = '0;
        end

        assign o_req_stb = busy_q;
        assign o_req     = (grant_q == GRANT_CODE) ? code_req : i_data_req;

        always_comb
        begin
                o_code_rsp     = '0;
                o_data_rsp     = '0;
                if (grant_q == GRANT_CODE)
                begin
                        o_code_rsp.ack = busy_q & i_rsp.ack;
                        o_code_rsp.dat = i_rsp.dat;
                end
                else
                begin
                        o_data_rsp.ack = busy_q & i_rsp.ack;
                        o_data_rsp.dat = i_rsp.dat;
                end
        end

        // Owner of the path is fixed for the whole transfer.
        a_grant_stable : assert property (
                @(posedge i_clk) disable iff (!i_rst_n)
                o_req_stb && !i_rsp.ack |=> o_req_stb && (grant_q == $past(grant_q))
        ) else $error("merger grant changed during an open request");

endmodule

//--- adapter/zap_wb_adapter.sv
// Store buffer front end and Wishbone classic master.
// Writes are posted into a FIFO and acked at once; the FSM
// drains them to the bus in order. A read only goes out once
// the buffer is empty and no bus write is open, so it always
// sees every earlier write. Read data returns one cycle after
// the bus ack.

`include "zap_defs.svh"

module zap_wb_adapter #(
        parameter int DEPTH = `ZAP_STORE_BUFFER_DEPTH
) (
        input  logic                   i_clk,
        input  logic                   i_rst_n,

        // Internal request path.
        input  logic                   i_req_stb,
        input  zap_pkg::zap_wb_req_t   i_req,
        output zap_pkg::zap_wb_rsp_t   o_rsp,

        // External Wishbone.
        output logic                   o_wb_cyc,
        output logic                   o_wb_stb,
        output logic                   o_wb_we,
        output zap_pkg::zap_word_t     o_wb_adr,
        output logic [`ZAP_SEL_W-1:0]  o_wb_sel,
        output zap_pkg::zap_word_t     o_wb_dat,
        input  logic                   i_wb_ack,
        input  zap_pkg::zap_word_t     i_wb_dat
);

        import zap_pkg::*;

        typedef enum logic [1:0] {
                S_IDLE,
                S_WRITE,
                S_READ
        } state_e;

        state_e      state_q;
        logic        bus_active_q;
        logic        ack_q;
        zap_wb_req_t bus_q;             // Request on the bus.
        zap_word_t   rdata_q;
        zap_wb_req_t fifo_head;
        logic        fifo_full;
        logic        fifo_empty;
        logic        push;
        logic        start_write;
        logic        start_read;
        logic        read_done;

        // ------------------------------
        // Store buffer
        // ------------------------------

        // A request stays on stb through its ack cycle, so ack_q blocks a second push.
        assign push = i_req_stb & i_req.we & ~fifo_full & ~ack_q;

        zap_sync_fifo #(
                .T      (zap_wb_req_t),
                .DEPTH  (DEPTH)
        ) u_store_buffer (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_push  (push),
                .i_wdata (i_req),
                .i_pop   (start_write),
                .o_rdata (fifo_head),
                .o_full  (fifo_full),
                .o_empty (fifo_empty)
        );

        // ------------------------------
        // Bus FSM
        // ------------------------------

        assign start_write = (state_q == S_IDLE) & ~fifo_empty;
        assign start_read  = (state_q == S_IDLE) & fifo_empty & i_req_stb & ~i_req.we & ~ack_q;
        assign read_done   = (state_q == S_READ) & i_wb_ack;

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state_q      <= S_IDLE;
                        bus_active_q <= 1'b0;
                        ack_q        <= 1'b0;
                end
                else
                begin
                        ack_q <= push | read_done;      // Write ack or read return.
                        case (state_q)
                        S_IDLE:
                        begin
                                if (start_write)
                                begin
                                        state_q      <= S_WRITE;
                                        bus_active_q <= 1'b1;
                                end
                                else if (start_read)
                                begin
                                        state_q      <= S_READ;
                                        bus_active_q <= 1'b1;
                                end
                        end
                        default:
                        begin
                                if (i_wb_ack)
                                begin
                                        state_q      <= S_IDLE;
                                        bus_active_q <= 1'b0;
                                end
                        end
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (start_write)
                        bus_q <= fifo_head;     // Oldest posted write.
                else if (start_read)
                        bus_q <= i_req;
                if (read_done)
                        rdata_q <= i_wb_dat;
        end

        // ------------------------------
        // Outputs
        // ------------------------------

        assign o_wb_cyc = bus_active_q;
        assign o_wb_stb = bus_active_q;
        assign o_wb_we  = bus_q.we;
        assign o_wb_adr = bus_q.adr;
        assign o_wb_sel = bus_q.sel;
        assign o_wb_dat = bus_q.dat;

        assign o_rsp.ack = ack_q;
        assign o_rsp.dat = rdata_q;

        // Classic cycle. Nothing moves until the slave acks.
        a_bus_stable : assert property (
                @(posedge i_clk) disable iff (!i_rst_n)
                o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(bus_q)
        ) else $error("wishbone request changed before ack");

endmodule

//--- adapter/zap_sync_fifo.sv
// Synchronous FIFO.
// Circular buffer with read and write pointers and an
// occupancy count. The head entry is visible on o_rdata
// while the FIFO is not empty.

module zap_sync_fifo #(
        parameter type T     = logic [7:0],
        parameter int  DEPTH = 16
) (
        input  logic i_clk,
        input  logic i_rst_n,
        input  logic i_push,
        input  T     i_wdata,
        input  logic i_pop,
        output T     o_rdata,
        output logic o_full,
        output logic o_empty
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        T                 mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr_q;
        logic [PTR_W-1:0] rd_ptr_q;
        logic [CNT_W-1:0] count_q;

        // Wraps at DEPTH, which need not be a power of two.
        function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
                return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        always_ff @(posedge i_clk)
        begin
                if (i_push)
                        mem[wr_ptr_q] <= i_wdata;
        end

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end
                else
                begin
                        if (i_push)
                                wr_ptr_q <= ptr_inc(wr_ptr_q);
                        if (i_pop)
                                rd_ptr_q <= ptr_inc(rd_ptr_q);
                        case ({i_push, i_pop})
                        2'b10:   count_q <= count_q + 1'b1;
                        2'b01:   count_q <= count_q - 1'b1;
                        default: count_q <= count_q;    // Both or neither.
                        endcase
                end
        end

        assign o_rdata = mem[rd_ptr_q];
        assign o_full  = (count_q == CNT_W'(DEPTH));
        assign o_empty = (count_q == '0);

        a_no_overflow : assert property (
                @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
        ) else $error("push into a full FIFO");

        a_no_underflow : assert property (
                @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty
        ) else $error("pop from an empty FIFO");

endmodule

//--- logic/zap_dual_rank_synchronizer.sv
// Interrupt level synchronizer.
// Brings asynchronous level inputs into the i_clk domain
// through a short chain of flops. Outputs are low in reset.

`include "zap_defs.svh"

module zap_dual_rank_synchronizer #(
        parameter int WIDTH = 1
) (
        input  logic             i_clk,
        input  logic             i_rst_n,
        input  logic [WIDTH-1:0] i_in,
        output logic [WIDTH-1:0] o_out
);

        logic [WIDTH-1:0] rank_q [`ZAP_SYNC_STAGES];

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        for (int i = 0; i < `ZAP_SYNC_STAGES; i++)
                                rank_q[i] <= '0;
                end
                else
                begin
                        rank_q[0] <= i_in;      // First rank may go metastable.
                        for (int i = 1; i < `ZAP_SYNC_STAGES; i++)
                                rank_q[i] <= rank_q[i-1];
                end
        end

        assign o_out = rank_q[`ZAP_SYNC_STAGES-1];

endmodule

//--- common/zap_pkg.sv
// ZAP memory fabric types.
// Request and response structs shared by the merger,
// the adapter and the top level, plus the grant encoding.

`include "zap_defs.svh"

package zap_pkg;

        // ------------------------------
        // Words
        // ------------------------------

        typedef logic [`ZAP_DATA_W-1:0] zap_word_t;

        // ------------------------------
        // Request and response
        // ------------------------------

        // One Wishbone transfer as seen on the internal path.
        typedef struct packed {
                logic [`ZAP_ADDR_W-1:0] adr;    // Byte address.
                logic                   we;     // High for a write.
                logic [`ZAP_SEL_W-1:0]  sel;    // Byte lanes.
                zap_word_t              dat;    // Write data.
        } zap_wb_req_t;

        // Ack is a single-cycle pulse, dat is valid with it.
        typedef struct packed {
                logic                   ack;
                zap_word_t              dat;    // Read data.
        } zap_wb_rsp_t;

        // ------------------------------
        // Arbitration
        // ------------------------------

        typedef enum logic {
                GRANT_CODE = 1'b0,
                GRANT_DATA = 1'b1
        } zap_grant_e;

endpackage

//--- common/zap_defs.svh
// ZAP memory fabric configuration.
// Bus widths, store buffer depth and interrupt
// synchronizer length for the memory-side path.

`ifndef ZAP_DEFS_SVH
`define ZAP_DEFS_SVH

// ------------------------------
// Wishbone bus widths
// ------------------------------

`define ZAP_ADDR_W              32      // Byte address.
`define ZAP_DATA_W              32      // One word.
`define ZAP_SEL_W               4       // One select per byte lane.

// ------------------------------
// Store buffer
// ------------------------------

// Posted writes held ahead of the bus.
`define ZAP_STORE_BUFFER_DEPTH  16

// ------------------------------
// Interrupt synchronizer
// ------------------------------

`define ZAP_SYNC_STAGES         2       // Ranks of flops.

`endif
